// ==== common/alut_pkg.sv ====
// alut package
// register map, commands and shared structs of the address lookup table

package alut_pkg;

   localparam int NUM_PORTS     = 4;  // switch ports
   localparam int D_PORT_SWITCH = 4;  // d_port bit for frames to the switch

   // register offsets, word aligned
   typedef enum logic [6:0] {
      al_frm_d_addr_l   = 7'h00,
      al_frm_d_addr_u   = 7'h04,
      al_frm_s_addr_l   = 7'h08,
      al_frm_s_addr_u   = 7'h0C,
      al_s_port         = 7'h10,
      al_d_port         = 7'h14,
      al_mac_addr_l     = 7'h18,
      al_mac_addr_u     = 7'h1C,
      al_cur_time       = 7'h20,
      al_bb_age         = 7'h24,
      al_div_clk        = 7'h28,
      al_command        = 7'h2C,
      al_status         = 7'h30,
      al_lst_inv_addr_l = 7'h34,
      al_lst_inv_addr_u = 7'h38,
      al_lst_inv_port   = 7'h3C
   } alut_reg_e;

   typedef enum logic [1:0] {
      cmd_none   = 2'd0,
      cmd_lookup = 2'd1,
      cmd_age    = 2'd2    // 3 reserved
   } alut_cmd_e;

   typedef struct packed {
      logic        sel;
      logic        enable;
      logic        write;
      logic [6:0]  addr;
      logic [31:0] wdata;
   } apb_req_t;

   // configuration held in the register bank
   typedef struct packed {
      logic [47:0] mac_addr;      // switch own address
      logic [47:0] d_addr;        // frame destination
      logic [47:0] s_addr;        // frame source
      logic [1:0]  s_port;
      logic [31:0] best_bfr_age;
      logic [7:0]  div_clk;
   } alut_cfg_t;

   typedef struct packed {
      logic        valid;
      logic [47:0] mac;
      logic [1:0]  port;
      logic [31:0] stamp;         // time of last learn
   } alut_entry_t;

   typedef struct packed {
      logic [47:0] addr;
      logic [1:0]  port;
   } lst_inv_t;

   typedef struct packed {
      logic        en;
      logic [7:0]  index;
      alut_entry_t entry;
   } tbl_wr_t;

endpackage

// ==== hw/alut/alut_reg_bank.sv ====
// alut register bank
// APB decode, configuration registers, self-clearing command
// and capture of the last invalidated table entry

module alut_reg_bank
   import alut_pkg::*;
(
   input  logic        pclk23,
   input  logic        n_p_reset23,
   input  apb_req_t    apb,
   input  logic [31:0] curr_time,
   input  logic        add_check_active,
   input  logic        inval_in_prog,
   input  logic        reused,
   input  logic [4:0]  d_port,
   input  lst_inv_t    lst_inv_nrm,
   input  lst_inv_t    lst_inv_cmd,
   output alut_cfg_t   cfg,
   output alut_cmd_e   command,
   output logic [31:0] prdata,
   output logic        clear_reused
);

   logic     read_en;
   logic     write_en;
   logic     active;
   lst_inv_t lst_inv;   // last invalidated address and port

   assign read_en  = apb.sel & ~apb.enable & ~apb.write;   // setup phase
   assign write_en = apb.sel & apb.enable & apb.write;     // access phase
   assign active   = add_check_active | inval_in_prog;

   // status read while idle acknowledges the reused flag
   assign clear_reused = read_en & (apb.addr == al_status) & ~active;

   // ----------------------------------------------------------------------
   // read mux
   // ----------------------------------------------------------------------
   always_ff @(posedge pclk23 or negedge n_p_reset23)
   begin
      if (!n_p_reset23)
         prdata <= '0;
      else if (read_en)
      begin
         case (apb.addr)
            al_frm_d_addr_l   : prdata <= cfg.d_addr[31:0];
            al_frm_d_addr_u   : prdata <= {16'd0, cfg.d_addr[47:32]};
            al_frm_s_addr_l   : prdata <= cfg.s_addr[31:0];
            al_frm_s_addr_u   : prdata <= {16'd0, cfg.s_addr[47:32]};
            al_s_port         : prdata <= {30'd0, cfg.s_port};
            al_d_port         : prdata <= {27'd0, d_port};
            al_mac_addr_l     : prdata <= cfg.mac_addr[31:0];
            al_mac_addr_u     : prdata <= {16'd0, cfg.mac_addr[47:32]};
            al_cur_time       : prdata <= curr_time;
            al_bb_age         : prdata <= cfg.best_bfr_age;
            al_div_clk        : prdata <= {24'd0, cfg.div_clk};
            al_status         : prdata <= {29'd0, reused, inval_in_prog, add_check_active};
            al_lst_inv_addr_l : prdata <= lst_inv.addr[31:0];
            al_lst_inv_addr_u : prdata <= {16'd0, lst_inv.addr[47:32]};
            al_lst_inv_port   : prdata <= {30'd0, lst_inv.port};
            default           : prdata <= '0;   // command, unmapped
         endcase
      end
      else
         prdata <= '0;   // only driven in access phase
   end

   // ----------------------------------------------------------------------
   // writable configuration
   // ----------------------------------------------------------------------
   always_ff @(posedge pclk23 or negedge n_p_reset23)
   begin
      if (!n_p_reset23)
         cfg <= '{best_bfr_age: '1, default: '0};   // nothing ages by default
      else if (write_en)
      begin
         case (apb.addr)
            al_frm_d_addr_l : cfg.d_addr[31:0]    <= apb.wdata;
            al_frm_d_addr_u : cfg.d_addr[47:32]   <= apb.wdata[15:0];
            al_frm_s_addr_l : cfg.s_addr[31:0]    <= apb.wdata;
            al_frm_s_addr_u : cfg.s_addr[47:32]   <= apb.wdata[15:0];
            al_s_port       : cfg.s_port          <= apb.wdata[1:0];
            al_mac_addr_l   : cfg.mac_addr[31:0]  <= apb.wdata;
            al_mac_addr_u   : cfg.mac_addr[47:32] <= apb.wdata[15:0];
            al_bb_age       : cfg.best_bfr_age    <= apb.wdata;
            al_div_clk      : cfg.div_clk         <= apb.wdata[7:0];
            default         : ;                   // read-only or unmapped
         endcase
      end
   end

   // command pulse, gone again one cycle after the write
   always_ff @(posedge pclk23 or negedge n_p_reset23)
   begin
      if (!n_p_reset23)
         command <= cmd_none;
      else if (command != cmd_none)
         command <= cmd_none;
      else if (write_en && apb.addr == al_command)
         command <= alut_cmd_e'(apb.wdata[1:0]);
   end

   // ----------------------------------------------------------------------
   // last invalidated entry, evictions win over aging
   // ----------------------------------------------------------------------
   always_ff @(posedge pclk23 or negedge n_p_reset23)
   begin
      if (!n_p_reset23)
         lst_inv <= '0;
      else if (reused)
         lst_inv <= lst_inv_nrm;   // overwritten by learning
      else if (inval_in_prog)
         lst_inv <= lst_inv_cmd;   // removed by age sweep
   end

endmodule

// ==== hw/alut/alut_timer.sv ====
// alut timer
// programmable clock divider feeding a free-running 32-bit time count

module alut_timer
(
   input  logic        pclk23,
   input  logic        n_p_reset23,
   input  logic [7:0]  div_clk,
   output logic [31:0] curr_time
);

   logic [7:0] div_cnt;
   logic [7:0] div_prev;   // detects a reprogrammed divider

   always_ff @(posedge pclk23 or negedge n_p_reset23)
   begin
      if (!n_p_reset23)
      begin
         div_cnt   <= '0;
         div_prev  <= '0;
         curr_time <= '0;
      end
      else if (div_clk != div_prev)
      begin
         div_prev <= div_clk;
         div_cnt  <= '0;   // restart the period
      end
      else if (div_cnt == div_clk)
      begin
         div_cnt   <= '0;
         curr_time <= curr_time + 32'd1;   // tick every div_clk+1 cycles
      end
      else
         div_cnt <= div_cnt + 8'd1;
   end

endmodule

// ==== hw/alut/alut_table.sv ====
// alut table
// address entries with two combinational read ports and one write per
// cycle, lookup side before aging side

module alut_table
   import alut_pkg::*;
#(
   parameter int NUM_ENTRIES = 4
)
(
   input  logic        pclk23,
   input  logic        n_p_reset23,
   input  logic [7:0]  chk_idx,
   input  logic [7:0]  age_idx,
   input  tbl_wr_t     chk_wr,
   input  tbl_wr_t     age_wr,
   output alut_entry_t chk_entry,
   output alut_entry_t age_entry
);

   localparam int IDX_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;

   alut_entry_t mem [NUM_ENTRIES];

   assign chk_entry = mem[chk_idx[IDX_W-1:0]];
   assign age_entry = mem[age_idx[IDX_W-1:0]];

   always_ff @(posedge pclk23 or negedge n_p_reset23)
   begin
      if (!n_p_reset23)
      begin
         for (int i = 0; i < NUM_ENTRIES; i++)
            mem[i] <= '0;   // all invalid
      end
      else if (chk_wr.en)
         mem[chk_wr.index[IDX_W-1:0]] <= chk_wr.entry;   // lookup has priority
      else if (age_wr.en)
         mem[age_wr.index[IDX_W-1:0]] <= age_wr.entry;
   end

endmodule

// ==== hw/alut/alut_addr_checker.sv ====
// alut address checker
// scans the table once per lookup, learns the source address and works
// out the destination port vector; evicts round-robin when full

module alut_addr_checker
   import alut_pkg::*;
#(
   parameter int NUM_ENTRIES = 4
)
(
   input  logic        pclk23,
   input  logic        n_p_reset23,
   input  alut_cmd_e   command,
   input  alut_cfg_t   cfg,
   input  logic [31:0] curr_time,
   input  logic        clear_reused,
   input  alut_entry_t rd_entry,
   output logic [7:0]  rd_idx,
   output tbl_wr_t     wr,
   output logic        add_check_active,
   output logic        reused,
   output logic [4:0]  d_port,
   output lst_inv_t    lst_inv_nrm
);

   localparam logic [7:0] LAST = 8'(NUM_ENTRIES - 1);

   typedef enum logic [1:0] {st_idle, st_scan, st_commit} state_e;

   state_e               state;
   logic [7:0]           scan_idx;
   logic [7:0]           evict_ptr;    // round-robin victim
   logic                 s_hit;
   logic                 free_found;
   logic                 d_hit;
   logic [7:0]           s_idx;
   logic [7:0]           free_idx;
   logic [1:0]           d_hit_port;
   logic                 s_match;
   logic                 d_match;
   logic                 evict;
   logic [7:0]           tgt_idx;
   logic [NUM_PORTS-1:0] src_mask;
   logic [4:0]           d_port_nxt;

   assign add_check_active = (state != st_idle);

   assign s_match = rd_entry.valid & (rd_entry.mac == cfg.s_addr);
   assign d_match = rd_entry.valid & (rd_entry.mac == cfg.d_addr);

   // commit target: refresh, free slot, else victim
   assign evict   = ~s_hit & ~free_found;
   assign tgt_idx = s_hit ? s_idx : (free_found ? free_idx : evict_ptr);
   assign rd_idx  = (state == st_commit) ? tgt_idx : scan_idx;   // old entry at commit

   assign wr.en          = (state == st_commit);
   assign wr.index       = tgt_idx;
   assign wr.entry.valid = 1'b1;
   assign wr.entry.mac   = cfg.s_addr;
   assign wr.entry.port  = cfg.s_port;
   assign wr.entry.stamp = curr_time;

   // destination vector
   assign src_mask = NUM_PORTS'(1) << cfg.s_port;

   always_comb
   begin
      if (cfg.d_addr == cfg.mac_addr)
         d_port_nxt = 5'(1) << D_PORT_SWITCH;       // for the switch itself
      else if (d_hit && cfg.d_addr != '1)
         d_port_nxt = 5'(1) << d_hit_port;          // known unicast
      else
         d_port_nxt = {1'b0, ~src_mask};            // flood, not back to source
   end

   // ----------------------------------------------------------------------
   // state machine
   // ----------------------------------------------------------------------
   always_ff @(posedge pclk23 or negedge n_p_reset23)
   begin
      if (!n_p_reset23)
      begin
         state      <= st_idle;
         scan_idx   <= '0;
         evict_ptr  <= '0;
         reused     <= 1'b0;
         d_port     <= '0;
         s_hit      <= 1'b0;
         free_found <= 1'b0;
         d_hit      <= 1'b0;
      end
      else
      begin
         if (clear_reused)
            reused <= 1'b0;
         case (state)
            st_idle :
               if (command == cmd_lookup)
               begin
                  state      <= st_scan;
                  s_hit      <= 1'b0;
                  free_found <= 1'b0;
                  d_hit      <= 1'b0;
               end
            st_scan :
            begin
               s_hit      <= s_hit | s_match;
               free_found <= free_found | ~rd_entry.valid;
               d_hit      <= d_hit | d_match;
               scan_idx   <= (scan_idx == LAST) ? '0 : scan_idx + 8'd1;
               if (scan_idx == LAST)
                  state <= st_commit;
            end
            st_commit :
            begin
               state  <= st_idle;
               d_port <= d_port_nxt;
               if (evict)
               begin
                  reused    <= 1'b1;
                  evict_ptr <= (evict_ptr == LAST) ? '0 : evict_ptr + 8'd1;
               end
            end
            default : state <= st_idle;
         endcase
      end
   end

   // scan results and evicted entry
   always_ff @(posedge pclk23)
   begin
      if (state == st_scan)
      begin
         if (s_match)
            s_idx <= scan_idx;
         if (!rd_entry.valid && !free_found)
            free_idx <= scan_idx;   // first free only
         if (d_match)
            d_hit_port <= rd_entry.port;
      end
      if (state == st_commit && evict)
         lst_inv_nrm <= lst_inv_t'{addr: rd_entry.mac, port: rd_entry.port};
   end

endmodule

// ==== hw/alut/alut_age_checker.sv ====
// alut age checker
// sweeps the table one entry per cycle and invalidates stale entries

module alut_age_checker
   import alut_pkg::*;
#(
   parameter int NUM_ENTRIES = 4
)
(
   input  logic        pclk23,
   input  logic        n_p_reset23,
   input  alut_cmd_e   command,
   input  logic [31:0] best_bfr_age,
   input  logic [31:0] curr_time,
   input  alut_entry_t rd_entry,
   output logic [7:0]  rd_idx,
   output tbl_wr_t     wr,
   output logic        inval_in_prog,
   output lst_inv_t    lst_inv_cmd
);

   localparam logic [7:0] LAST = 8'(NUM_ENTRIES - 1);

   typedef enum logic {st_idle, st_sweep} state_e;

   state_e     state;
   logic [7:0] idx;
   logic       stale;
   lst_inv_t   lst_inv_q;   // last removed

   assign inval_in_prog = (state == st_sweep);
   assign rd_idx        = idx;

   // age by wrapping difference
   assign stale = inval_in_prog & rd_entry.valid
                & ((curr_time - rd_entry.stamp) > best_bfr_age);

   assign wr.en          = stale;
   assign wr.index       = idx;
   assign wr.entry       = {1'b0, rd_entry.mac, rd_entry.port, rd_entry.stamp};

   // removal visible to the bank in its own cycle
   assign lst_inv_cmd = stale ? lst_inv_t'{addr: rd_entry.mac, port: rd_entry.port}
                              : lst_inv_q;

   always_ff @(posedge pclk23 or negedge n_p_reset23)
   begin
      if (!n_p_reset23)
      begin
         state     <= st_idle;
         idx       <= '0;
         lst_inv_q <= '0;
      end
      else
      begin
         if (stale)
            lst_inv_q <= lst_inv_cmd;
         case (state)
            st_idle :
               if (command == cmd_age)
                  state <= st_sweep;   // idx already 0
            st_sweep :
            begin
               idx <= (idx == LAST) ? '0 : idx + 8'd1;
               if (idx == LAST)
                  state <= st_idle;
            end
            default : state <= st_idle;
         endcase
      end
   end

endmodule

// ==== hw/alut_top.sv ====
// alut top level
// register bank, timer, table and the two checkers

module alut_top
   import alut_pkg::*;
#(
   parameter int NUM_ENTRIES = 4
)
(
   input  logic        pclk23,
   input  logic        n_p_reset23,
   input  apb_req_t    apb,
   output logic [31:0] prdata
);

   alut_cfg_t   cfg;
   alut_cmd_e   command;
   logic        clear_reused;
   logic [31:0] curr_time;
   logic        add_check_active;
   logic        inval_in_prog;
   logic        reused;
   logic [4:0]  d_port;
   lst_inv_t    lst_inv_nrm;
   lst_inv_t    lst_inv_cmd;
   tbl_wr_t     chk_wr;
   tbl_wr_t     age_wr;
   logic [7:0]  chk_idx;
   logic [7:0]  age_idx;
   alut_entry_t chk_entry;
   alut_entry_t age_entry;

   alut_reg_bank i_reg_bank (
      .pclk23           (pclk23),
      .n_p_reset23      (n_p_reset23),
      .apb              (apb),
      .curr_time        (curr_time),
      .add_check_active (add_check_active),
      .inval_in_prog    (inval_in_prog),
      .reused           (reused),
      .d_port           (d_port),
      .lst_inv_nrm      (lst_inv_nrm),
      .lst_inv_cmd      (lst_inv_cmd),
      .cfg              (cfg),
      .command          (command),
      .prdata           (prdata),
      .clear_reused     (clear_reused)
   );

   alut_timer i_timer (
      .pclk23      (pclk23),
      .n_p_reset23 (n_p_reset23),
      .div_clk     (cfg.div_clk),
      .curr_time   (curr_time)
   );

   alut_table #(.NUM_ENTRIES(NUM_ENTRIES)) i_table (
      .pclk23      (pclk23),
      .n_p_reset23 (n_p_reset23),
      .chk_idx     (chk_idx),
      .age_idx     (age_idx),
      .chk_wr      (chk_wr),
      .age_wr      (age_wr),
      .chk_entry   (chk_entry),
      .age_entry   (age_entry)
   );

   // lookup side
   alut_addr_checker #(.NUM_ENTRIES(NUM_ENTRIES)) i_addr_checker (
      .pclk23           (pclk23),
      .n_p_reset23      (n_p_reset23),
      .command          (command),
      .cfg              (cfg),
      .curr_time        (curr_time),
      .clear_reused     (clear_reused),
      .rd_entry         (chk_entry),
      .rd_idx           (chk_idx),
      .wr               (chk_wr),
      .add_check_active (add_check_active),
      .reused           (reused),
      .d_port           (d_port),
      .lst_inv_nrm      (lst_inv_nrm)
   );

   // aging side
   alut_age_checker #(.NUM_ENTRIES(NUM_ENTRIES)) i_age_checker (
      .pclk23        (pclk23),
      .n_p_reset23   (n_p_reset23),
      .command       (command),
      .best_bfr_age  (cfg.best_bfr_age),
      .curr_time     (curr_time),
      .rd_entry      (age_entry),
      .rd_idx        (age_idx),
      .wr            (age_wr),
      .inval_in_prog (inval_in_prog),
      .lst_inv_cmd   (lst_inv_cmd)
   );

endmodule

// ==== verification/tb_clock_gen.sv ====
// testbench clock and reset
// 10 ns clock, reset held low for three cycles

module tb_clock_gen
(
   output logic pclk23,
   output logic n_p_reset23
);

   timeunit 1ns;
   timeprecision 100ps;

   initial
   begin
      pclk23      = 1'b0;
      n_p_reset23 = 1'b0;
      repeat (3) @(posedge pclk23);
      @(negedge pclk23);   // release away from the active edge
      n_p_reset23 = 1'b1;
   end

   always #5 pclk23 = ~pclk23;

endmodule

// ==== verification/tb_alut.sv ====
// alut testbench
// drives the alut over APB, keeps a reference model of the table and
// checks registers, learning, forwarding, eviction, timer and aging

module tb_alut
   import alut_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int          NUM_ENTRIES = 4;
   localparam int          MAX_CYCLES  = 20000;
   localparam int          TIMER_DIV   = 3;     // time ticks every 4 cycles
   localparam logic [47:0] BCAST       = '1;

   logic        pclk23;
   logic        n_p_reset23;
   apb_req_t    apb;
   logic [31:0] prdata;

   int          cycle_cnt = 0;
   logic [31:0] rng_state = 32'he96e;   // lcg seed

   // ----------------------------------------------------------------------
   // reference model of the table
   // ----------------------------------------------------------------------
   logic        m_valid [NUM_ENTRIES];
   logic [47:0] m_mac   [NUM_ENTRIES];
   logic [1:0]  m_port  [NUM_ENTRIES];
   int          m_stamp [NUM_ENTRIES];   // cycle of last learn
   int          rr_ptr;                  // next victim
   logic [47:0] inv_mac;                 // last removed entry
   logic [1:0]  inv_port;
   logic [47:0] switch_mac;
   int          bb_age;

   tb_clock_gen i_clk_gen (
      .pclk23      (pclk23),
      .n_p_reset23 (n_p_reset23)
   );

   alut_top #(.NUM_ENTRIES(NUM_ENTRIES)) i_dut (
      .pclk23      (pclk23),
      .n_p_reset23 (n_p_reset23),
      .apb         (apb),
      .prdata      (prdata)
   );

   // run limit
   always @(posedge pclk23)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES)
      begin
         $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
         $display("sim failed");
         $fatal(1, "timeout");
      end
   end

   function logic [31:0] lcg_next();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   function automatic logic [47:0] rand_mac();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = lcg_next();
      lo = lcg_next();
      return {hi[31:16], lo};
   endfunction

   // writable bits of each register, zero for read-only
   function automatic logic [31:0] write_mask(input alut_reg_e r);
      case (r)
         al_frm_d_addr_l, al_frm_s_addr_l, al_mac_addr_l, al_bb_age : return '1;
         al_frm_d_addr_u, al_frm_s_addr_u, al_mac_addr_u : return 32'h0000_FFFF;
         al_s_port  : return 32'h3;
         al_div_clk : return 32'hFF;
         default    : return '0;
      endcase
   endfunction

   // forwarding rules, evaluated on the table before learning
   function automatic logic [4:0] expect_d_port(input logic [47:0] d, input logic [1:0] sport);
      logic       hit;
      logic [1:0] p;
      hit = 1'b0;
      p   = '0;
      if (d == switch_mac)
         return 5'b10000;   // to the switch only
      for (int i = 0; i < NUM_ENTRIES; i++)
         if (m_valid[i] && m_mac[i] == d)
         begin
            hit = 1'b1;
            p   = m_port[i];
         end
      if (hit && d != BCAST)
         return 5'(1) << p;
      return {1'b0, ~(4'b0001 << sport)};   // flood, skip source
   endfunction

   // ----------------------------------------------------------------------
   // APB access, inputs change on the falling edge
   // ----------------------------------------------------------------------
   task automatic apb_write(input logic [6:0] addr, input logic [31:0] data);
      @(negedge pclk23);
      apb.sel    = 1'b1;   // setup
      apb.enable = 1'b0;
      apb.write  = 1'b1;
      apb.addr   = addr;
      apb.wdata  = data;
      @(negedge pclk23);
      apb.enable = 1'b1;   // access
      @(negedge pclk23);
      apb.sel    = 1'b0;
      apb.enable = 1'b0;
      apb.write  = 1'b0;
   endtask

   task automatic apb_read(input logic [6:0] addr, output logic [31:0] data);
      @(negedge pclk23);
      apb.sel    = 1'b1;
      apb.enable = 1'b0;
      apb.write  = 1'b0;
      apb.addr   = addr;
      @(negedge pclk23);
      apb.enable = 1'b1;
      data       = prdata;   // registered at the setup edge
      @(negedge pclk23);
      apb.sel    = 1'b0;
      apb.enable = 1'b0;
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("ERROR: time %0t, %s read 0x%08h, expected 0x%08h", $time, name, got, exp);
         $display("sim failed");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic check_within(input string name, input int got, input int exp);
      assert (got >= exp - 1 && got <= exp + 1)
      else
      begin
         $display("ERROR: time %0t, %s is %0d, expected %0d within one", $time, name, got, exp);
         $display("sim failed");
         $fatal(1, "value out of range");
      end
   endtask

   task automatic check_reg(input alut_reg_e r, input logic [31:0] exp);
      logic [31:0] got;
      apb_read(r, got);
      check_value(r.name(), got, exp);
   endtask

   task automatic set_addr(input alut_reg_e lo, input alut_reg_e hi, input logic [47:0] v);
      apb_write(lo, v[31:0]);
      apb_write(hi, {16'd0, v[47:32]});
   endtask

   // poll status until both busy bits drop
   task automatic wait_idle(output logic [31:0] status);
      int start;
      start  = cycle_cnt;
      status = 32'h3;
      while (status[1:0] != 2'b00)
      begin
         if (cycle_cnt - start > NUM_ENTRIES + 4)
         begin
            $display("status still busy %0d cycles after a command", cycle_cnt - start);
            $display("sim failed");
            $fatal(1, "check did not finish");
         end
         apb_read(al_status, status);
      end
   endtask

   task automatic check_last_inv();
      check_reg(al_lst_inv_addr_l, inv_mac[31:0]);
      check_reg(al_lst_inv_addr_u, {16'd0, inv_mac[47:32]});
      check_reg(al_lst_inv_port, {30'd0, inv_port});
   endtask

   // model side of a lookup: refresh, first free, else round-robin victim
   task automatic model_learn(input logic [47:0] s, input logic [1:0] sport,
                              output logic evicted);
      int hit;
      int free;
      int tgt;
      hit     = -1;
      free    = -1;
      evicted = 1'b0;
      for (int i = 0; i < NUM_ENTRIES; i++)
      begin
         if (m_valid[i] && m_mac[i] == s && hit < 0)
            hit = i;
         if (!m_valid[i] && free < 0)
            free = i;
      end
      if (hit >= 0)
         tgt = hit;
      else if (free >= 0)
         tgt = free;
      else
      begin
         tgt      = rr_ptr;
         inv_mac  = m_mac[tgt];
         inv_port = m_port[tgt];
         rr_ptr   = (rr_ptr + 1) % NUM_ENTRIES;
         evicted  = 1'b1;
      end
      m_valid[tgt] = 1'b1;
      m_mac[tgt]   = s;
      m_port[tgt]  = sport;
      m_stamp[tgt] = cycle_cnt;
   endtask

   task automatic run_lookup(input logic [47:0] s, input logic [47:0] d,
                             input logic [1:0] sport);
      logic [4:0]  exp_port;
      logic        evicted;
      logic [31:0] status;
      exp_port = expect_d_port(d, sport);
      set_addr(al_frm_s_addr_l, al_frm_s_addr_u, s);
      set_addr(al_frm_d_addr_l, al_frm_d_addr_u, d);
      apb_write(al_s_port, {30'd0, sport});
      apb_write(al_command, {30'd0, cmd_lookup});
      model_learn(s, sport, evicted);
      wait_idle(status);
      check_value("status", status, {29'd0, evicted, 2'b00});   // reused seen once
      check_reg(al_d_port, {27'd0, exp_port});
      if (evicted)
      begin
         check_last_inv();
         check_reg(al_status, 32'd0);   // acknowledged by the idle poll
      end
   endtask

   task automatic run_age();
      logic [31:0] status;
      int          now;
      logic        removed;
      apb_write(al_command, {30'd0, cmd_age});
      now     = cycle_cnt;
      removed = 1'b0;
      for (int i = 0; i < NUM_ENTRIES; i++)
         if (m_valid[i] && (now - m_stamp[i]) / (TIMER_DIV + 1) > bb_age)
         begin
            m_valid[i] = 1'b0;
            inv_mac    = m_mac[i];   // last one in index order wins
            inv_port   = m_port[i];
            removed    = 1'b1;
         end
      wait_idle(status);
      check_value("status", status, 32'd0);
      if (removed)
         check_last_inv();
   endtask

   // ----------------------------------------------------------------------
   // test sequence
   // ----------------------------------------------------------------------
   initial
   begin
      logic [31:0] v;
      logic [31:0] t0;
      logic [31:0] t1;
      logic [6:0]  holes [4];
      logic [47:0] src   [4];
      logic [47:0] s;
      logic [47:0] d;
      logic [47:0] gone;
      logic [1:0]  sport;
      alut_reg_e   r;
      int          sel;
      int          c0;

      apb    = '0;
      rr_ptr = 0;
      for (int i = 0; i < NUM_ENTRIES; i++)
         m_valid[i] = 1'b0;
      inv_mac  = '0;
      inv_port = '0;
      @(posedge n_p_reset23);

      // reset values, time already counting
      for (int a = 0; a <= 'h3C; a += 4)
      begin
         r = alut_reg_e'(a);
         if (r != al_cur_time)
            check_reg(r, (r == al_bb_age) ? 32'hFFFF_FFFF : 32'h0);
      end

      // write and read back, truncated to width
      for (int a = 0; a <= 'h3C; a += 4)
      begin
         r = alut_reg_e'(a);
         if (write_mask(r) != '0)
         begin
            v = lcg_next();
            apb_write(r, v);
            check_reg(r, v & write_mask(r));
         end
      end
      holes = '{7'h02, 7'h40, 7'h5C, 7'h7C};
      for (int i = 0; i < 4; i++)
      begin
         apb_read(holes[i], v);
         check_value("unmapped offset", v, 32'd0);
      end
      apb_write(al_command, 32'h3);   // reserved, both checkers stay idle
      check_reg(al_command, 32'd0);
      check_reg(al_status, 32'd0);

      // learning and forwarding
      switch_mac = rand_mac();
      set_addr(al_mac_addr_l, al_mac_addr_u, switch_mac);
      for (int i = 0; i < 4; i++)
         src[i] = rand_mac();
      run_lookup(src[0], rand_mac(), 2'd0);   // miss
      run_lookup(src[1], src[0], 2'd1);       // unicast hit
      run_lookup(src[2], BCAST, 2'd2);
      run_lookup(src[3], switch_mac, 2'd3);
      for (int n = 0; n < 10; n++)
      begin
         s     = src[int'(lcg_next() >> 16) % 4];
         sport = 2'(lcg_next() >> 30);
         sel   = int'(lcg_next() >> 16) % 4;
         case (sel)
            0       : d = src[int'(lcg_next() >> 16) % 4];
            1       : d = rand_mac();
            2       : d = BCAST;
            default : d = switch_mac;
         endcase
         run_lookup(s, d, sport);
      end

      // fifth and sixth sources, table full
      run_lookup(rand_mac(), src[1], 2'(lcg_next() >> 30));
      run_lookup(rand_mac(), src[2], 2'(lcg_next() >> 30));   // victim pointer moved on

      // timer
      apb_write(al_div_clk, TIMER_DIV);
      apb_read(al_cur_time, t0);
      c0 = cycle_cnt;
      repeat (41) @(negedge pclk23);
      apb_read(al_cur_time, t1);
      check_within("cur_time delta", int'(t1 - t0), (cycle_cnt - c0) / (TIMER_DIV + 1));

      // aging, refresh entries 1 and 3 after a long pause
      bb_age = 30;
      apb_write(al_bb_age, bb_age);
      repeat (600) @(negedge pclk23);
      run_lookup(m_mac[1], switch_mac, m_port[1]);
      run_lookup(m_mac[3], BCAST, m_port[3]);
      gone = m_mac[0];
      run_age();
      run_lookup(m_mac[1], gone, m_port[1]);       // removed, floods
      run_lookup(m_mac[1], m_mac[3], m_port[1]);   // survivor, unicast

      $display("sim passed");
      $finish;
   end

endmodule

// ==== vlog.f ====
common/alut_pkg.sv
hw/alut/alut_reg_bank.sv
hw/alut/alut_timer.sv
hw/alut/alut_table.sv
hw/alut/alut_addr_checker.sv
hw/alut/alut_age_checker.sv
hw/alut_top.sv
verification/tb_clock_gen.sv
verification/tb_alut.sv

// ==== Makefile ====
# Verilator build and run for the alut testbench

VERILATOR ?= verilator
TOP       ?= tb_alut
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
